// File: src/rv_isa_pkg.sv
/*
 * RV32I instruction word definitions for the fetch unit
 * Holds the opcodes the branch predictor looks at, the B-type and J-type
 * field layouts, and a packed union that reads one word both ways
 */
package rv_isa_pkg;

    // Raw 32-bit instruction as it comes back from instruction memory
    typedef logic [31:0] inst_t;

    typedef logic [6:0] opcode_t;  // Major opcode field, bits 6..0

    // Control transfer opcodes seen by the static predictor
    localparam opcode_t OPC_BRANCH = 7'b110_0011;  // BEQ, BNE, BLT, BGE, BLTU, BGEU
    localparam opcode_t OPC_JAL    = 7'b110_1111;  // Direct jump with 20-bit offset
    localparam opcode_t OPC_JALR   = 7'b110_0111;  // Indirect jump, target needs rs1

    // Canonical NOP, addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

    // B-type layout
    // The offset is scattered so that the sign always sits in bit 31
    typedef struct packed {
        logic       imm12;    // Offset bit 12, sign
        logic [5:0] imm10_5;  // Offset bits 10..5
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;   // Compare kind
        logic [3:0] imm4_1;   // Offset bits 4..1
        logic       imm11;    // Offset bit 11
        opcode_t    opcode;
    } b_fmt_t;

    // J-type layout
    // Offset bits are shuffled as well, bit 0 is implied zero
    typedef struct packed {
        logic       imm20;     // Offset bit 20, sign
        logic [9:0] imm10_1;   // Offset bits 10..1
        logic       imm11;     // Offset bit 11
        logic [7:0] imm19_12;  // Offset bits 19..12
        logic [4:0] rd;        // Link register
        opcode_t    opcode;
    } j_fmt_t;

    // One fetched word viewed as raw bits, as a branch or as a jump
    // All three views are 32 bits wide and share the opcode position
    typedef union packed {
        inst_t  raw;
        b_fmt_t b;
        j_fmt_t j;
    } rv_inst_u;

endpackage

// File: src/ifu_pkg.sv
/*
 * Fetch unit address definitions
 * Address type, the PC taken after reset and the sequential fetch step
 */
package ifu_pkg;

    localparam int unsigned ADDR_W = 32;  // Byte address width

    // Instruction fetch address, always byte based
    typedef logic [ADDR_W-1:0] addr_t;

    // First fetch address once reset is released
    localparam addr_t RESET_VECTOR = 32'h0000_0080;

    // No compressed instructions, so every step is one full word
    localparam addr_t INST_BYTES = 32'd4;

endpackage

// File: src/sbpu.sv
/*
 * Static branch predictor
 * Backward conditional branches and every JAL are predicted taken,
 * JALR never is. Purely combinational on the fetched word and its PC
 */
module sbpu (
    input  rv_isa_pkg::inst_t inst_i,          // Word returned by instruction memory
    input  ifu_pkg::addr_t    pc_i,            // Address that word was fetched from
    output logic              branch_taken_o,  // Prediction, not gated by valid
    output ifu_pkg::addr_t    branch_addr_o    // Predicted target
);

    import rv_isa_pkg::*;
    import ifu_pkg::*;

    rv_inst_u inst_u;  // Same bits, read as branch or as jump
    logic     is_branch;
    logic     is_jal;
    addr_t    b_imm;   // Sign-extended branch offset
    addr_t    j_imm;   // Sign-extended jump offset
    addr_t    target;

    assign inst_u = rv_inst_u'(inst_i);

    // Opcode sits in the same place for both views
    assign is_branch = (inst_u.b.opcode == OPC_BRANCH);
    assign is_jal    = (inst_u.j.opcode == OPC_JAL);

    // Reassemble the scattered immediates, bit 0 is always zero
    always_comb begin
        b_imm = {{20{inst_u.b.imm12}}, inst_u.b.imm11, inst_u.b.imm10_5,
                 inst_u.b.imm4_1, 1'b0};
        j_imm = {{12{inst_u.j.imm20}}, inst_u.j.imm19_12, inst_u.j.imm11,
                 inst_u.j.imm10_1, 1'b0};
    end

    // Loops close backwards, so a negative branch offset is guessed taken
    // A JAL always jumps
    assign branch_taken_o = (is_branch & b_imm[ADDR_W-1]) | is_jal;

    always_comb begin
        case (inst_u.b.opcode)
            OPC_BRANCH: target = pc_i + b_imm;  // Computed even for forward branches
            OPC_JAL:    target = pc_i + j_imm;
            // JALR lands here too, its base register is not known at fetch
            default:    target = pc_i;  // Not a predicted control transfer
        endcase
    end

    assign branch_addr_o = target;

endmodule

// File: src/ifu_pc_gen.sv
/*
 * Fetch PC generator
 * Keeps the next fetch address and issues one memory request per cycle.
 * Redirect wins over an applied prediction, which wins over stall replay
 */
module ifu_pc_gen (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           redirect_i,     // Pulse from execute
    input  ifu_pkg::addr_t redirect_pc_i,  // Corrected fetch address
    input  logic           pred_apply_i,   // Accepted taken prediction
    input  ifu_pkg::addr_t pred_target_i,  // Predicted target address
    input  logic           stall_i,        // Decode holds its input
    input  ifu_pkg::addr_t hold_pc_i,      // PC of the word decode is holding
    output logic           req_o,          // Memory request strobe
    output ifu_pkg::addr_t pc_o            // Memory request address
);

    import ifu_pkg::*;

    logic  req_q;  // Goes high one edge after reset and stays high
    addr_t pc_q;   // Next address on the sequential or steered path
    addr_t pc_d;

    // Next address on the fetch path
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;  // Execute knows best
        end else if (pred_apply_i) begin
            pc_d = pred_target_i;  // Steer onto the predicted path
        end else if (stall_i || !req_q) begin
            pc_d = pc_q;  // Nothing consumed, keep the address for later
        end else begin
            pc_d = pc_q + INST_BYTES;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
            pc_q  <= RESET_VECTOR;
        end else begin
            req_q <= 1'b1;
            pc_q  <= pc_d;
        end
    end

    assign req_o = req_q;

    // While decode is stalled the held word is requested again, so memory
    // keeps returning it and the response stage never sees the next word
    // The sequential address stays in pc_q until the stall drops
    assign pc_o = stall_i ? hold_pc_i : pc_q;

    // Holds for redirect targets, predicted targets and replays alike
    a_req_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        req_o |-> (pc_o[1:0] == 2'b00)
    ) else $error("Fetch request to unaligned address %h", pc_o);

endmodule

// File: src/ifu_resp_stage.sv
/*
 * Fetch response stage
 * Tracks the request that is in flight to memory, kills words fetched on
 * a wrong path, and presents the returning word and its PC to decode
 */
module ifu_resp_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              req_i,         // Request issued this cycle
    input  ifu_pkg::addr_t    req_pc_i,      // Its address
    input  rv_isa_pkg::inst_t rdata_i,       // Word for last cycle's request
    input  logic              redirect_i,    // Kills the request issued now
    input  logic              stall_i,       // Decode does not accept
    input  logic              pred_taken_i,  // Raw prediction for rdata_i
    output logic              valid_o,       // Word on inst_o is on the right path
    output ifu_pkg::addr_t    pc_o,          // Its PC
    output rv_isa_pkg::inst_t inst_o,
    output logic              pred_apply_o   // Steer fetch to the target
);

    import ifu_pkg::*;

    logic  valid_q;  // The request now answered by memory is still wanted
    addr_t pc_q;     // Address of that request
    logic  pred_apply;

    // A prediction only counts for a live word that decode takes this cycle
    assign pred_apply = valid_q & ~stall_i & pred_taken_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            pc_q    <= RESET_VECTOR;
        end else if (redirect_i) begin
            // Request going out now is on the old path
            valid_q <= 1'b0;
            if (!stall_i) begin
                pc_q <= req_pc_i;
            end
        end else if (!stall_i) begin
            // The sequential request issued alongside a taken prediction is dropped
            valid_q <= req_i & ~pred_apply;
            pc_q    <= req_pc_i;
        end
        // Under stall the replayed request carries the same PC, keep everything
    end

    assign valid_o      = valid_q;
    assign pc_o         = pc_q;
    assign inst_o       = rdata_i;  // Memory answers exactly one cycle later
    assign pred_apply_o = pred_apply;

    // The word fetched in a redirect cycle must never reach decode
    a_redirect_kill: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        redirect_i |=> !valid_o
    ) else $error("Wrong-path word valid after redirect");

    // Decode relies on a frozen PC while it holds the word
    a_stall_pc_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (stall_i && valid_o) |=> $stable(pc_o)
    ) else $error("pc_o changed under stall");

endmodule

// File: src/ifu_top.sv
/*
 * Instruction fetch unit
 * Two-stage front end of an RV32I core with a static branch predictor.
 * Drives a synchronous instruction memory and feeds decode
 */
module ifu_top (
    input  logic              clk,
    input  logic              arst_n_i,
    // Instruction memory
    output logic              imem_req_o,
    output ifu_pkg::addr_t    imem_addr_o,
    input  rv_isa_pkg::inst_t imem_rdata_i,   // Word for last cycle's address
    // Decode
    input  logic              stall_i,
    // Execute
    input  logic              redirect_i,
    input  ifu_pkg::addr_t    redirect_pc_i,
    // To decode
    output logic              inst_valid_o,
    output rv_isa_pkg::inst_t inst_o,
    output ifu_pkg::addr_t    pc_o,
    output logic              pred_taken_o,   // Raw predictor output
    output ifu_pkg::addr_t    pred_target_o
);

    import rv_isa_pkg::*;
    import ifu_pkg::*;

    logic  fetch_req;    // Request strobe from the PC generator
    addr_t fetch_pc;     // Request address
    logic  resp_valid;   // Returning word is on the right path
    addr_t resp_pc;      // PC of the returning word
    inst_t resp_inst;
    logic  pred_taken;
    addr_t pred_target;
    logic  pred_apply;   // Prediction accepted together with its word

    ifu_pc_gen i_ifu_pc_gen (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pred_apply_i  (pred_apply),
        .pred_target_i (pred_target),
        .stall_i       (stall_i),
        .hold_pc_i     (resp_pc),  // Replay source while decode stalls
        .req_o         (fetch_req),
        .pc_o          (fetch_pc)
    );

    ifu_resp_stage i_ifu_resp_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (fetch_req),
        .req_pc_i     (fetch_pc),
        .rdata_i      (imem_rdata_i),
        .redirect_i   (redirect_i),
        .stall_i      (stall_i),
        .pred_taken_i (pred_taken),
        .valid_o      (resp_valid),
        .pc_o         (resp_pc),
        .inst_o       (resp_inst),
        .pred_apply_o (pred_apply)
    );

    sbpu i_sbpu (
        .inst_i         (resp_inst),
        .pc_i           (resp_pc),
        .branch_taken_o (pred_taken),
        .branch_addr_o  (pred_target)
    );

    assign imem_req_o    = fetch_req;
    assign imem_addr_o   = fetch_pc;
    assign inst_valid_o  = resp_valid;
    assign inst_o        = resp_inst;
    assign pc_o          = resp_pc;
    assign pred_taken_o  = pred_taken;
    assign pred_target_o = pred_target;

endmodule

// File: dv/ifu_tb.sv
/*
 * Testbench for the instruction fetch unit
 * Sparse memory model, scenario table with stalls and redirects, and a
 * reference model that follows the accepted PC stream
 */
module ifu_tb;

    import rv_isa_pkg::*;
    import ifu_pkg::*;

    typedef enum logic [1:0] {K_ALU, K_BR, K_JAL, K_JALR} kind_t;  // Fragment word kind

    // One scenario, entered by a redirect unless it is the reset row
    typedef struct packed {
        logic  jump_in;    // Pulse redirect to start in the row's first cycle
        addr_t start;
        addr_t frag_pc;    // Address of the control word of the fragment
        kind_t kind;
        int    off;        // Branch or jump offset in bytes
        int    n_accept;   // Row ends after this many accepted words
        int    stall_at;   // Row cycle where a stall begins, -1 for none
        int    stall_max;  // Longest random stall
        int    redir_at;   // Row cycle of an extra redirect, -1 for none
        addr_t redir_pc;
    } row_t;

    localparam int NUM_ROWS = 10;
    localparam int unsigned SEED = 32'h4926142b;

    logic  clk = 1'b0;
    logic  arst_n_i;
    logic  imem_req_o;
    addr_t imem_addr_o;
    inst_t imem_rdata_i;
    logic  stall_i;
    logic  redirect_i;
    addr_t redirect_pc_i;
    logic  inst_valid_o;
    inst_t inst_o;
    addr_t pc_o;
    logic  pred_taken_o;
    addr_t pred_target_o;

    row_t  rows [NUM_ROWS];
    inst_t mem [addr_t];      // Program words, anything else reads as NOP
    logic  tkn_map [addr_t];  // Expected prediction per address
    addr_t tgt_map [addr_t];  // Expected predicted target per address

    int unsigned seed;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    addr_t exp_next;          // PC the next accepted word must have
    logic  was_held;          // Last cycle held a valid word under stall
    logic  was_redirect;
    addr_t held_pc;
    inst_t held_inst;
    addr_t last_req;          // Address requested in the previous cycle
    int    taken_seen;
    int    hold_seen;

    ifu_top i_ifu_top (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    always #5 clk = ~clk;

    function automatic inst_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : INST_NOP;
    endfunction

    function automatic logic taken_of(input addr_t a);
        return tkn_map.exists(a) ? tkn_map[a] : 1'b0;
    endfunction

    function automatic addr_t target_of(input addr_t a);
        return tgt_map.exists(a) ? tgt_map[a] : a;  // Plain words point at themselves
    endfunction

    // Builds the instruction bits from the ISA field layout
    function automatic inst_t encode(input kind_t kind, input int off);
        logic [31:0] o;
        inst_t       w;
        o = off;
        case (kind)
            // BNE x1, x2
            K_BR:    w = {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], 7'b110_0011};
            K_JAL:   w = {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b110_1111};  // JAL x1
            K_JALR:  w = 32'h0000_8067;  // JALR x0, 0(x1)
            default: w = 32'h0010_8093;  // ADDI x1, x1, 1
        endcase
        return w;
    endfunction

    // Synchronous memory, the word shows up one cycle after its request
    always @(posedge clk) begin
        if (imem_req_o) imem_rdata_i <= mem_word(imem_addr_o);
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the accepted stream stopped short", cycle_cnt);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("Fail at time %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            $display("Fail at time %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at time %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic set_row(input int idx, input logic jump_in, input addr_t start,
                           input addr_t frag_pc, input kind_t kind, input int off,
                           input int n_accept, input int stall_at, input int stall_max,
                           input int redir_at, input addr_t redir_pc);
        rows[idx] = {jump_in, start, frag_pc, kind, off, n_accept, stall_at, stall_max,
                     redir_at, redir_pc};
    endtask

    // Puts the fragment word in memory and records what the predictor should say
    task automatic load_row(input row_t r);
        mem[r.frag_pc]     = encode(r.kind, r.off);
        tkn_map[r.frag_pc] = (r.kind == K_BR && r.off < 0) || r.kind == K_JAL;
        tgt_map[r.frag_pc] = (r.kind == K_BR || r.kind == K_JAL) ?
                             r.frag_pc + addr_t'(r.off) : r.frag_pc;
    endtask

    // Reference model and output checks, called once per cycle after driving
    task automatic observe();
        addr_t cur;
        check_flag("imem_req_o", 1'b1, imem_req_o);  // Requests run every cycle after reset
        if (was_held && !was_redirect) begin
            check_flag("inst_valid_o", 1'b1, inst_valid_o);  // A held word cannot vanish
            check_addr("pc_o", held_pc, pc_o);
            check_inst("inst_o", held_inst, inst_o);
            hold_seen++;
        end
        if (inst_valid_o) begin
            check_inst("inst_o", mem_word(pc_o), inst_o);
            check_flag("pred_taken_o", taken_of(pc_o), pred_taken_o);
            check_addr("pred_target_o", target_of(pc_o), pred_target_o);
        end
        if (inst_valid_o && stall_i) begin
            check_addr("imem_addr_o", exp_next, imem_addr_o);  // Held word is fetched again
        end
        if (inst_valid_o && !stall_i) begin
            check_addr("pc_o", exp_next, pc_o);  // Catches skipped or repeated words
            check_addr("imem_addr_o", exp_next, last_req);  // Asked for one cycle earlier
            cur = exp_next;
            if (taken_of(cur)) taken_seen++;
            exp_next = taken_of(cur) ? target_of(cur) : cur + INST_BYTES;
        end
        if (redirect_i) exp_next = redirect_pc_i;  // Execute overrides any guess
        was_held     = inst_valid_o & stall_i;
        was_redirect = redirect_i;
        held_pc      = pc_o;
        held_inst    = inst_o;
        last_req     = imem_addr_o;
    endtask

    task automatic run_row(input row_t r);
        int cyc;
        int acc;
        int stall_left;
        cyc        = 0;
        acc        = 0;
        stall_left = 0;
        while (acc < r.n_accept) begin
            @(negedge clk);
            redirect_i = 1'b0;
            if (r.jump_in && cyc == 0) begin
                redirect_i    = 1'b1;
                redirect_pc_i = r.start;
            end
            if (cyc == r.redir_at) begin
                redirect_i    = 1'b1;
                redirect_pc_i = r.redir_pc;
            end
            if (cyc == r.stall_at) stall_left = 1 + ($urandom % r.stall_max);
            stall_i = (stall_left > 0);
            if (stall_left > 0) stall_left--;
            #1;  // Let the combinational outputs follow the new inputs
            observe();
            if (inst_valid_o && !stall_i) acc++;
            cyc++;
        end
    endtask

    initial begin
        int stim_cycles;
        seed = SEED;
        void'($urandom(seed));
        arst_n_i      = 1'b0;
        stall_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        imem_rdata_i  = INST_NOP;
        exp_next      = RESET_VECTOR;
        was_held      = 1'b0;
        was_redirect  = 1'b0;
        last_req      = '0;
        taken_seen    = 0;
        hold_seen     = 0;

        //      jump start       frag_pc      kind    off  acc stall max redir redir_pc
        set_row(0, 0, 32'h0080, 32'h008C, K_BR,   -8,  10, -1, 0, -1, 32'h0);    // Backward loop
        set_row(1, 1, 32'h0200, 32'h0208, K_BR,   16,  6,  -1, 0, -1, 32'h0);    // Forward branch
        set_row(2, 1, 32'h0300, 32'h0304, K_JAL,  64,  5,  -1, 0, -1, 32'h0);
        set_row(3, 1, 32'h0400, 32'h040C, K_JAL,  -12, 8,  -1, 0, -1, 32'h0);
        set_row(4, 1, 32'h0500, 32'h0504, K_JALR, 0,   5,  -1, 0, -1, 32'h0);
        set_row(5, 1, 32'h0600, 32'h0604, K_BR,   -4,  6,  -1, 0, 3,  32'h0680);  // With taken guess
        set_row(6, 1, 32'h0700, 32'h0704, K_ALU,  0,   5,  3,  4, 3,  32'h0780);  // With stall
        set_row(7, 1, 32'h0800, 32'h0808, K_BR,   -8,  8,  4,  6, -1, 32'h0);    // Stalled branch
        set_row(8, 1, 32'h0900, 32'h0900, K_ALU,  0,   6,  3,  5, -1, 32'h0);
        set_row(9, 1, 32'h0A00, 32'h0A04, K_JAL,  8,   5,  4,  4, -1, 32'h0);    // Stall in bubble

        stim_cycles = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            load_row(rows[i]);
            stim_cycles += rows[i].n_accept + rows[i].stall_max + 3;
        end
        cycle_limit = 4 * stim_cycles + 50;

        // Nothing may leave the unit while reset is held
        repeat (4) begin
            @(negedge clk);
            check_flag("imem_req_o", 1'b0, imem_req_o);
            check_flag("inst_valid_o", 1'b0, inst_valid_o);
        end
        arst_n_i = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        if (taken_seen == 0 || hold_seen == 0) begin
            $display("Scenarios did not reach a taken prediction and a held word");
            $display("TESTS FAILED");
            $fatal(1, "Coverage of scenarios incomplete");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: ifu_top.f
src/rv_isa_pkg.sv
src/ifu_pkg.sv
src/sbpu.sv
src/ifu_pc_gen.sv
src/ifu_resp_stage.sv
src/ifu_top.sv
dv/ifu_tb.sv

// File: Bender.yml
package:
  name: ifu_top

dependencies: {}

sources:
  # Packages come first, the modules import them
  - src/rv_isa_pkg.sv
  - src/ifu_pkg.sv
  # Fetch unit RTL, top level last
  - src/sbpu.sv
  - src/ifu_pc_gen.sv
  - src/ifu_resp_stage.sv
  - src/ifu_top.sv
  # Testbench, top module ifu_tb
  - target: test
    files:
      - dv/ifu_tb.sv
